// File: Bender.yml
package:
  name: lane_buffer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lane_payload_pkg.sv
      - logic/lane_flow_pkg.sv
      - logic/lane_link_if.sv
      - logic/lane_pop_if.sv
      - logic/credit_sender.sv
      - logic/lane_fifo.sv
      - logic/lane_drain_arbiter.sv
      - logic/lane_buffer_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/lane_buffer_checker.sv
      - verif/lane_buffer_tb.sv

// File: lane_buffer_top.f
+incdir+logic
logic/lane_payload_pkg.sv
logic/lane_flow_pkg.sv
logic/lane_link_if.sv
logic/lane_pop_if.sv
logic/credit_sender.sv
logic/lane_fifo.sv
logic/lane_drain_arbiter.sv
logic/lane_buffer_top.sv
verif/lane_buffer_checker.sv
verif/lane_buffer_tb.sv

// File: logic/credit_sender.sv
`timescale 1ns/1ps

`include "lane_buffer_config.svh"

// Front end of the lane buffer
// It keeps one credit counter per lane and only lets a word in when the
// tagged lane still has room reserved for it
module credit_sender
  import lane_payload_pkg::*;
  import lane_flow_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // Input stream with a lane tag per word
  input  logic        in_valid,
  output logic        in_ready,
  input  lane_id_t    in_lane,
  input  lane_data_t  in_data,

  // One credit/valid push link per lane
  lane_link_if.sender links [`LANE_COUNT]
);

  // ------------------------------
  // Per-lane status
  // ------------------------------

  // High for a lane whose counter is nonzero
  logic [`LANE_COUNT-1:0] has_credit;

  // High for the lane that receives the word in this cycle
  logic [`LANE_COUNT-1:0] take;

  // Credit pulses coming back from the FIFOs
  logic [`LANE_COUNT-1:0] credit_ret;

  // Input handshake of this cycle
  logic in_accept;

  // Ready depends only on the tagged lane, so a full lane never blocks
  // a word headed for another lane once the tag changes
  assign in_ready = has_credit[in_lane];
  assign in_accept = in_valid && in_ready;

  // ------------------------------
  // Counters and steering
  // ------------------------------

  for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
    // Credits still available for this lane
    credit_t credit_q;

    assign has_credit[g] = (credit_q != '0);
    assign credit_ret[g] = links[g].push_credit;
    assign take[g] = in_accept && (in_lane == lane_id_t'(g));

    // Only the tagged lane sees a strobe
    assign links[g].push_valid = take[g];
    // The word goes out on every link, the strobe decides who keeps it
    assign links[g].push_data = in_data;

    // A push spends a credit and a returned pulse refunds one
    // When both happen in the same cycle the count stays put
    always_ff @(posedge clk) begin
      if (rst) begin
        credit_q <= credit_t'(`LANE_DEPTH);
      end else if (take[g] && !credit_ret[g]) begin
        credit_q <= credit_q - 1'b1;
      end else if (!take[g] && credit_ret[g]) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

endmodule

// File: logic/lane_buffer_config.svh
`ifndef LANE_BUFFER_CONFIG_SVH
`define LANE_BUFFER_CONFIG_SVH

// Build-time sizing of the lane buffer

// Number of independent lanes behind the single input stream
`define LANE_COUNT 4

// Entries per lane FIFO
// Each lane also starts out with this many credits
`define LANE_DEPTH 4

// Bits per data word
`define DATA_WIDTH 16

// Set to 1 to let a push into an empty lane appear on its pop side in the same cycle
// Set to 0 to always pass through the flop RAM first
`define LANE_BYPASS 1

`endif

// File: logic/lane_buffer_top.sv
`timescale 1ns/1ps

`include "lane_buffer_config.svh"

// Credit-managed multi-lane packet buffer
// Words come in tagged with a lane, wait in that lane's FIFO and leave
// through a round-robin drain onto one output stream
module lane_buffer_top
  import lane_payload_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Input stream, one word per in_valid and in_ready handshake
  input  logic       in_valid,
  output logic       in_ready,
  input  lane_id_t   in_lane,
  input  lane_data_t in_data,

  // Output stream, one word per out_valid and out_ready handshake
  output logic       out_valid,
  input  logic       out_ready,
  output lane_id_t   out_lane,
  output lane_data_t out_data
);

  // ------------------------------
  // Per-lane links
  // ------------------------------

  // Push side from the sender into each lane
  lane_link_if links [`LANE_COUNT] ();

  // Pop side from each lane into the arbiter
  lane_pop_if pops [`LANE_COUNT] ();

  credit_sender credit_sender_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_lane  (in_lane),
    .in_data  (in_data),
    .links    (links)
  );

  // All lanes are built the same way
  for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
    lane_fifo #(
      .depth         (`LANE_DEPTH),
      .width         (`DATA_WIDTH),
      .enable_bypass (`LANE_BYPASS)
    ) lane_fifo_i (
      .clk  (clk),
      .rst  (rst),
      .push (links[g]),
      .pop  (pops[g])
    );
  end

  lane_drain_arbiter lane_drain_arbiter_i (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_lane  (out_lane),
    .out_data  (out_data),
    .pops      (pops)
  );

endmodule

// File: logic/lane_drain_arbiter.sv
`timescale 1ns/1ps

`include "lane_buffer_config.svh"

// Merges the lane FIFOs onto the output stream in round-robin order
module lane_drain_arbiter
  import lane_payload_pkg::*;
  import lane_flow_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  output logic       out_valid,
  input  logic       out_ready,
  output lane_id_t   out_lane,
  output lane_data_t out_data,

  lane_pop_if.arbiter pops [`LANE_COUNT]
);

  logic [`LANE_COUNT-1:0] valid_vec;
  lane_data_t data_vec [`LANE_COUNT];

  // Lane where the next search starts, one past the last grant
  lane_id_t start_q;
  lane_id_t start_next;

  // Lane kept while the output waits for out_ready
  lane_id_t held_q;
  arb_state_t state_q;

  // Result of the round-robin search and the lane actually granted
  logic found;
  lane_id_t pick;
  lane_id_t grant;

  for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
    assign valid_vec[g] = pops[g].pop_valid;
    assign data_vec[g] = pops[g].pop_data;
    // Only the granted lane pops, and only when the output actually moves
    assign pops[g].pop_ready = out_valid && out_ready && (grant == lane_id_t'(g));
  end

  // First valid lane at or after start_q, wrapping around
  always_comb begin
    int idx;
    found = 1'b0;
    pick = start_q;
    for (int k = 0; k < `LANE_COUNT; k++) begin
      idx = (int'(start_q) + k) % `LANE_COUNT;
      if (!found && valid_vec[idx]) begin
        found = 1'b1;
        pick = lane_id_t'(idx);
      end
    end
  end

  // In arb_hold the search is ignored so lane and data stay put under back-pressure
  assign grant = (state_q == arb_hold) ? held_q : pick;
  assign out_valid = (state_q == arb_hold) ? valid_vec[held_q] : found;
  assign out_lane = grant;
  assign out_data = data_vec[grant];

  assign start_next = (grant == lane_id_t'(`LANE_COUNT - 1)) ? '0 : grant + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= arb_idle;
      held_q <= '0;
      start_q <= '0;
    end else begin
      case (state_q)
        arb_idle: if (found && !out_ready) begin
          state_q <= arb_hold;
          held_q <= pick;
        end
        arb_hold: if (out_ready) state_q <= arb_idle;
        default: state_q <= arb_idle;
      endcase
      // Fairness pointer moves only when a word is really handed off
      if (out_valid && out_ready) start_q <= start_next;
    end
  end

endmodule

// File: logic/lane_fifo.sv
`timescale 1ns/1ps

`include "lane_buffer_config.svh"

// One lane of the buffer
// Words arrive on a credit/valid push link and leave on a ready/valid pop link.
// Storage is a small flop RAM addressed by a write and a read pointer.
// With bypass on, a push into an empty FIFO shows up on the pop side in the
// same cycle and skips the RAM if it is taken right away
module lane_fifo
  import lane_payload_pkg::*;
  import lane_flow_pkg::*;
#(
  // Number of stored words, also the credit budget of the sender for this lane
  parameter int depth = `LANE_DEPTH,
  // Bits per stored word
  parameter int width = `DATA_WIDTH,
  // 1 gives zero-cycle cut-through when empty at the cost of a push to pop path
  parameter bit enable_bypass = `LANE_BYPASS
) (
  input logic       clk,
  input logic       rst,

  lane_link_if.fifo push,
  lane_pop_if.fifo  pop
);

  // ------------------------------
  // Storage and bookkeeping
  // ------------------------------

  // Flop RAM holding depth words
  logic [width-1:0] mem [depth];

  // Next slot to write and next slot to read
  ram_addr_t wr_ptr;
  ram_addr_t rd_ptr;

  // Words held in the RAM
  occupancy_t count;

  // Head of the RAM as seen by the pop side
  lane_data_t ram_word;

  logic empty;
  logic bypass_now;
  logic bypass_taken;
  logic pop_fire;
  logic ram_write;
  logic ram_read;

  // Registered credit pulse back to the sender
  logic credit_q;

  // Pointers wrap at depth so that depths other than a power of two still work
  function automatic ram_addr_t ptr_advance(ram_addr_t ptr);
    if (ptr == ram_addr_t'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------
  // Pop side
  // ------------------------------

  assign empty = (count == '0);
  assign ram_word = mem[rd_ptr];

  // The incoming word is offered directly only while nothing older is stored
  assign bypass_now = enable_bypass && empty && push.push_valid;

  assign pop.pop_valid = !empty || bypass_now;
  assign pop.pop_data = bypass_now ? push.push_data : ram_word;

  assign pop_fire = pop.pop_valid && pop.pop_ready;

  // A bypassed word that pops right away never touches the RAM
  assign bypass_taken = bypass_now && pop_fire;

  // ------------------------------
  // RAM write and read control
  // ------------------------------

  // The credit scheme guarantees a free slot for every push
  assign ram_write = push.push_valid && !bypass_taken;

  // Any pop that was not served by the bypass consumes the RAM head
  assign ram_read = pop_fire && !bypass_taken;

  always_ff @(posedge clk) begin
    if (ram_write) begin
      mem[wr_ptr] <= push.push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_q <= 1'b0;
    end else begin
      if (ram_write) begin
        wr_ptr <= ptr_advance(wr_ptr);
      end
      if (ram_read) begin
        rd_ptr <= ptr_advance(rd_ptr);
      end

      // Simultaneous write and read leave the fill level unchanged
      if (ram_write && !ram_read) begin
        count <= count + 1'b1;
      end else if (!ram_write && ram_read) begin
        count <= count - 1'b1;
      end

      // Every word that leaves frees one slot whether it was bypassed or not
      credit_q <= pop_fire;
    end
  end

  // ------------------------------
  // Credit return
  // ------------------------------

  // High for exactly one cycle, the cycle after each pop
  assign push.push_credit = credit_q;

endmodule

// File: logic/lane_flow_pkg.sv
`include "lane_buffer_config.svh"

// Types for flow control and bookkeeping inside the buffer
package lane_flow_pkg;

  // Sender side credit counter
  // It must be able to hold the full depth, so one extra bit over the address
  typedef logic [$clog2(`LANE_DEPTH + 1)-1:0] credit_t;

  // Number of words currently stored in one lane FIFO
  typedef logic [$clog2(`LANE_DEPTH + 1)-1:0] occupancy_t;

  // Read or write pointer into the flop RAM of a lane
  typedef logic [$clog2(`LANE_DEPTH)-1:0] ram_addr_t;

  // Drain arbiter states
  // In arb_hold the arbiter keeps its choice until the output handshake completes
  typedef enum logic {
    arb_idle,
    arb_hold
  } arb_state_t;

endpackage

// File: logic/lane_link_if.sv
`timescale 1ns/1ps

// Credit/valid push link between the credit sender and one lane FIFO
interface lane_link_if
  import lane_payload_pkg::*;
();

  // Single-cycle strobe, one word per cycle it is high
  logic push_valid;

  // Word that goes with push_valid
  lane_data_t push_data;

  // Single-cycle pulse from the FIFO
  // Every pulse hands exactly one credit back to the sender
  logic push_credit;

  // The sender raises push_valid only while it still holds a credit for this lane
  modport sender (
    output push_valid,
    output push_data,
    input  push_credit
  );

  // The FIFO side never stalls a push, it relies on the credit count instead
  modport fifo (
    input  push_valid,
    input  push_data,
    output push_credit
  );

endinterface

// File: logic/lane_payload_pkg.sv
`include "lane_buffer_config.svh"

// Types for what the buffer carries
package lane_payload_pkg;

  // ------------------------------
  // Data path
  // ------------------------------

  // One word as it enters and leaves the buffer
  typedef logic [`DATA_WIDTH-1:0] lane_data_t;

  // ------------------------------
  // Lane tagging
  // ------------------------------

  // Lane number that travels with each word on input and output
  typedef logic [$clog2(`LANE_COUNT)-1:0] lane_id_t;

endpackage

// File: logic/lane_pop_if.sv
`timescale 1ns/1ps

// Ready/valid pop link between one lane FIFO and the drain arbiter
interface lane_pop_if
  import lane_payload_pkg::*;
();

  // The FIFO holds pop_valid high and pop_data stable until the word is taken
  logic pop_valid;
  lane_data_t pop_data;

  // Driven by the arbiter
  // A word leaves in any cycle where pop_valid and pop_ready are both high
  logic pop_ready;

  modport fifo (
    output pop_valid,
    output pop_data,
    input  pop_ready
  );

  modport arbiter (
    input  pop_valid,
    input  pop_data,
    output pop_ready
  );

endinterface

// File: verif/lane_buffer_checker.sv
`timescale 1ns/1ps

`include "lane_buffer_config.svh"

// Watches the buffer ports and compares them with a per-lane queue model
module lane_buffer_checker
  import lane_payload_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  logic       in_ready,
  input  lane_id_t   in_lane,
  input  lane_data_t in_data,
  input  logic       out_valid,
  input  logic       out_ready,
  input  lane_id_t   out_lane,
  input  lane_data_t out_data,
  output int         error_count,
  output logic       model_empty
);

  // Words accepted but not yet seen on the output, one queue per lane
  lane_data_t model_q [`LANE_COUNT][$];

  // Lanes that popped last cycle and still owe the sender a credit
  logic [`LANE_COUNT-1:0] credit_pend;

  lane_id_t last_grant;
  // Set when the previous cycle offered a word that was not taken
  logic hold_q;
  lane_id_t held_lane;
  lane_data_t held_data;
  int err_count = 0;
  logic empty_q = 1'b1;

  assign error_count = err_count;
  assign model_empty = empty_q;

  // Expected grant, the first non-empty lane after the last grant, wrapping around
  function automatic lane_id_t next_lane(lane_id_t last, logic [`LANE_COUNT-1:0] mask);
    int idx;
    bit found;
    found = 1'b0;
    next_lane = last;
    for (int k = 1; k <= `LANE_COUNT; k++) begin
      idx = (int'(last) + k) % `LANE_COUNT;
      if (!found && mask[idx]) begin
        found = 1'b1;
        next_lane = lane_id_t'(idx);
      end
    end
  endfunction

  task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("ERROR %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    err_count++;
  endtask

  // ------------------------------
  // Comparing process
  // ------------------------------

  always @(posedge clk) begin
    logic [`LANE_COUNT-1:0] mask;
    int credits;
    logic in_fire;
    logic out_fire;
    lane_data_t exp_data;
    if (rst) begin
      for (int l = 0; l < `LANE_COUNT; l++) model_q[l].delete();
      credit_pend = '0;
      // Pointer starts at lane 0, so the last grant counts as the top lane
      last_grant = lane_id_t'(`LANE_COUNT - 1);
      hold_q = 1'b0;
      empty_q <= 1'b1;
    end else begin
      in_fire = in_valid && in_ready;
      out_fire = out_valid && out_ready;

      // Sender credits are the depth minus stored words minus credits still in flight
      credits = `LANE_DEPTH - model_q[in_lane].size() - int'(credit_pend[in_lane]);
      if (in_ready !== (credits > 0)) report_value("in_ready", in_ready, credits > 0);

      for (int l = 0; l < `LANE_COUNT; l++) mask[l] = (model_q[l].size() != 0);
      // A word pushed into an empty lane is already offered when bypass is on
      if (`LANE_BYPASS && in_fire) mask[in_lane] = 1'b1;

      if (hold_q) begin
        // Under back-pressure the offered word must not move
        if (out_valid !== 1'b1) report_value("out_valid", out_valid, 1'b1);
        if (out_lane !== held_lane) report_value("out_lane", out_lane, held_lane);
        if (out_data !== held_data) report_value("out_data", out_data, held_data);
      end else begin
        if (out_valid !== (|mask)) report_value("out_valid", out_valid, |mask);
        if (out_valid && (|mask) && out_lane !== next_lane(last_grant, mask))
          report_value("out_lane", out_lane, next_lane(last_grant, mask));
      end

      // Push first so a bypassed word can leave in its own cycle
      if (in_fire) model_q[in_lane].push_back(in_data);

      credit_pend = '0;
      if (out_fire) begin
        if (model_q[out_lane].size() == 0) begin
          $display("unexpected output word on lane %0d, nothing is stored there", out_lane);
          err_count++;
        end else begin
          exp_data = model_q[out_lane].pop_front();
          if (out_data !== exp_data) report_value("out_data", out_data, exp_data);
        end
        credit_pend[out_lane] = 1'b1;
        last_grant = out_lane;
      end

      hold_q = out_valid && !out_ready;
      held_lane = out_lane;
      held_data = out_data;

      empty_q <= 1'b1;
      for (int l = 0; l < `LANE_COUNT; l++) begin
        if (model_q[l].size() != 0) empty_q <= 1'b0;
      end
    end
  end

endmodule

// File: verif/lane_buffer_tb.sv
`timescale 1ns/1ps

`include "lane_buffer_config.svh"

module lane_buffer_tb
  import lane_payload_pkg::*;
();

  localparam int wait_limit = 200;

  logic clk = 1'b0;
  logic rst;
  logic in_valid;
  logic in_ready;
  lane_id_t in_lane;
  lane_data_t in_data;
  logic out_valid;
  logic out_ready;
  lane_id_t out_lane;
  lane_data_t out_data;
  int check_errors;
  logic model_empty;
  int timeouts = 0;

  always #4 clk = ~clk;

  lane_buffer_top lane_buffer_top_i (.*);

  lane_buffer_checker lane_buffer_checker_i (.*, .error_count(check_errors));

  // Offers one word and keeps it up until the buffer takes it
  task automatic push_word(input lane_id_t lane);
    int waited;
    bit done;
    @(negedge clk);
    in_valid = 1'b1;
    in_lane = lane;
    in_data = lane_data_t'($urandom);
    done = 1'b0;
    waited = 0;
    while (!done && waited < wait_limit) begin
      @(posedge clk);
      done = in_ready;
      waited++;
    end
    if (!done) begin
      $display("timeout waiting for in_ready");
      timeouts++;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // Fills every lane to its credit limit with the output blocked
  task automatic fill_all();
    out_ready = 1'b0;
    for (int l = 0; l < `LANE_COUNT; l++) begin
      for (int k = 0; k < `LANE_DEPTH; k++) push_word(lane_id_t'(l));
    end
    // Show each full lane to the checker so it can see in_ready low
    for (int l = 0; l < `LANE_COUNT; l++) begin
      @(negedge clk);
      in_lane = lane_id_t'(l);
    end
  endtask

  // Empties the buffer, optionally with out_ready toggling every cycle
  task automatic drain(input bit toggle_ready);
    int waited;
    waited = 0;
    in_valid = 1'b0;
    do begin
      @(negedge clk);
      out_ready = toggle_ready ? ~out_ready : 1'b1;
      waited++;
    end while (!model_empty && waited < wait_limit);
    if (!model_empty) begin
      $display("timeout waiting for out_valid");
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(46));
    rst = 1'b1;
    in_valid = 1'b0;
    in_lane = '0;
    in_data = '0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // ------------------------------
    // Directed phases
    // ------------------------------

    // Idle scan of all lanes right after reset
    for (int l = 0; l < `LANE_COUNT; l++) begin
      @(negedge clk);
      in_lane = lane_id_t'(l);
    end
    fill_all();
    // Several blocked cycles, then a drain with alternating back-pressure
    repeat (4) @(negedge clk);
    drain(1'b1);
    // All credits must be back for a second full load
    fill_all();
    drain(1'b0);

    // ------------------------------
    // Random traffic
    // ------------------------------

    repeat (400) begin
      @(negedge clk);
      in_valid = $urandom % 2;
      in_lane = lane_id_t'($urandom);
      in_data = lane_data_t'($urandom);
      out_ready = $urandom % 2;
    end
    drain(1'b0);
    repeat (4) @(negedge clk);

    $display("closing count: %0d checker errors, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
